// ==== design/stream_pkg.sv ====
/* Defaults and shared types for the two-source stream merger.
   NUM_SRC is fixed at 2 because the top level has two named source ports. */
package stream_pkg;

   // Default payload width in bits. tlast travels next to it and is not counted here.
   localparam int unsigned DATA_W = 72;

   // Default FIFO depth is 2**DEPTH_LOG2 words per source.
   localparam int unsigned DEPTH_LOG2 = 4;

   localparam int unsigned NUM_SRC = 2;  // number of merged input streams.

   // Identifies which input stream an output word came from.
   typedef logic [$clog2(NUM_SRC)-1:0] src_id_t;

   localparam src_id_t SRC_A = src_id_t'(0);  // words from the a input.
   localparam src_id_t SRC_B = src_id_t'(1);  // words from the b input.

   // The arbiter is idle between packets and busy while one packet is in flight.
   typedef enum logic {
      ARB_IDLE,  // no grant held, the next source is picked here.
      ARB_BUSY   // grant held until the tlast transfer.
   } arb_state_t;

endpackage

// ==== design/axis_if.sv ====
/* Valid/ready stream with tlast. A word moves on a rising edge with tvalid and tready high.
   The source keeps tvalid, tdata and tlast steady until that edge. */
interface axis_if #(
   parameter int WIDTH = 72
);

   logic [WIDTH-1:0] tdata;   // payload word.
   logic             tlast;   // marks the final word of a packet.
   logic             tvalid;
   logic             tready;  // may depend on tvalid.

   modport source (
      output tdata,
      output tlast,
      output tvalid,
      input  tready
   );

   modport sink (
      input  tdata,
      input  tlast,
      input  tvalid,
      output tready
   );

endinterface

// ==== design/axis_flop2.sv ====
/* Two-entry register stage for one clock domain. o_tready is a flop, so it stays low
   in reset and for one cycle after the release. */
module axis_flop2 #(
   parameter int WIDTH = 73
) (
   input  logic             i_clk,
   input  logic             i_arst_n,
   input  logic [WIDTH-1:0] i_tdata,
   input  logic             i_tvalid,
   output logic             o_tready,
   output logic [WIDTH-1:0] o_tdata,
   output logic             o_tvalid,
   input  logic             i_tready
);

   logic [WIDTH-1:0] head_q;        // oldest word, shown at the output.
   logic [WIDTH-1:0] skid_q;        // catches the word in flight when i_tready drops.
   logic             head_vld;
   logic             skid_vld;
   logic             head_vld_nxt;
   logic             skid_vld_nxt;
   logic             push;
   logic             pop;

   assign push = i_tvalid & o_tready;
   assign pop  = head_vld & i_tready;

   always_comb begin
      head_vld_nxt = head_vld;
      skid_vld_nxt = skid_vld;
      if (pop) begin
         head_vld_nxt = skid_vld | push;  // the skid word or the new word moves up.
         skid_vld_nxt = skid_vld & push;
      end else if (push) begin
         head_vld_nxt = 1'b1;
         skid_vld_nxt = head_vld;          // a held head sends the new word to the skid.
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         head_vld <= 1'b0;
         skid_vld <= 1'b0;
         o_tready <= 1'b0;
      end else begin
         head_vld <= head_vld_nxt;
         skid_vld <= skid_vld_nxt;
         o_tready <= ~skid_vld_nxt;  // ready while fewer than two entries are held.
      end
   end

   always_ff @(posedge i_clk) begin
      if (pop) begin
         head_q <= skid_vld ? skid_q : i_tdata;
         if (skid_vld && push) begin
            skid_q <= i_tdata;
         end
      end else if (push) begin
         if (head_vld) begin
            skid_q <= i_tdata;
         end else begin
            head_q <= i_tdata;
         end
      end
   end

   assign o_tdata  = head_q;
   assign o_tvalid = head_vld;

endmodule

// ==== design/axis_2clk_fifo.sv ====
/* Dual-clock FIFO of 2**DEPTH_LOG2 words with tlast stored beside the data.
   DEPTH_LOG2 must be at least 2. Reset is asserted asynchronously and released through
   a two-flop synchronizer in each clock domain. */
module axis_2clk_fifo #(
   parameter int    WIDTH      = 72,
   parameter int    DEPTH_LOG2 = 4,
   parameter string PIPELINE   = "INOUT"  // one of NONE, IN, OUT or INOUT.
) (
   input  logic             i_arst_n,
   input  logic             i_s_axis_aclk,
   input  logic [WIDTH-1:0] i_s_axis_tdata,
   input  logic             i_s_axis_tlast,
   input  logic             i_s_axis_tvalid,
   output logic             o_s_axis_tready,
   input  logic             i_m_axis_aclk,
   axis_if.source           m
);

   localparam int DEPTH  = 2**DEPTH_LOG2;
   localparam int WORD_W = WIDTH + 1;  // tlast sits in the top bit.

   typedef logic [DEPTH_LOG2:0] ptr_t;  // one extra bit tells full from empty.
   typedef logic [WORD_W-1:0]   word_t;

   function automatic ptr_t bin2gray(input ptr_t bin);
      return bin ^ (bin >> 1);
   endfunction

   logic [1:0] dom_clk;       // index 0 is the write domain and 1 the read domain.
   logic [1:0] dom_rst_n;
   ptr_t       gray_ptr  [2]; // each domain's own gray pointer.
   ptr_t       gray_sync [2]; // the other domain's gray pointer after two flops.

   assign dom_clk = {i_m_axis_aclk, i_s_axis_aclk};

   // Both domains get the same reset release and pointer crossing logic.
   for (genvar g = 0; g < 2; g++) begin : g_dom
      logic [1:0] rst_q;
      ptr_t       sync_q1;
      ptr_t       sync_q2;

      always_ff @(posedge dom_clk[g] or negedge i_arst_n) begin
         if (!i_arst_n) begin
            rst_q <= '0;
         end else begin
            rst_q <= {rst_q[0], 1'b1};
         end
      end

      assign dom_rst_n[g] = rst_q[1];

      always_ff @(posedge dom_clk[g] or negedge dom_rst_n[g]) begin
         if (!dom_rst_n[g]) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
         end else begin
            sync_q1 <= gray_ptr[1-g];  // only one bit changes per step, so this is safe.
            sync_q2 <= sync_q1;
         end
      end

      assign gray_sync[g] = sync_q2;
   end

   word_t in_tdata;    // word at the memory write port.
   logic  in_tvalid;
   logic  in_tready;
   word_t out_tdata;   // word at the memory read port.
   logic  out_tvalid;
   logic  out_tready;
   word_t m_word;
   logic  m_tvalid;

   if (PIPELINE == "IN" || PIPELINE == "INOUT") begin : g_in_pipe
      axis_flop2 #(.WIDTH(WORD_W)) in_pipe_i (
         .i_clk    (i_s_axis_aclk),
         .i_arst_n (dom_rst_n[0]),
         .i_tdata  ({i_s_axis_tlast, i_s_axis_tdata}),
         .i_tvalid (i_s_axis_tvalid),
         .o_tready (o_s_axis_tready),
         .o_tdata  (in_tdata),
         .o_tvalid (in_tvalid),
         .i_tready (in_tready)
      );
   end else begin : g_in_direct
      assign in_tdata        = {i_s_axis_tlast, i_s_axis_tdata};
      assign in_tvalid       = i_s_axis_tvalid;
      assign o_s_axis_tready = in_tready;
   end

   if (PIPELINE == "OUT" || PIPELINE == "INOUT") begin : g_out_pipe
      axis_flop2 #(.WIDTH(WORD_W)) out_pipe_i (
         .i_clk    (i_m_axis_aclk),
         .i_arst_n (dom_rst_n[1]),
         .i_tdata  (out_tdata),
         .i_tvalid (out_tvalid),
         .o_tready (out_tready),
         .o_tdata  (m_word),
         .o_tvalid (m_tvalid),
         .i_tready (m.tready)
      );
   end else begin : g_out_direct
      assign m_word     = out_tdata;
      assign m_tvalid   = out_tvalid;
      assign out_tready = m.tready;
   end

   assign m.tdata  = m_word[WIDTH-1:0];
   assign m.tlast  = m_word[WIDTH];
   assign m.tvalid = m_tvalid;

   word_t mem [DEPTH];
   ptr_t  wr_bin;
   ptr_t  wr_gray;
   ptr_t  wr_bin_nxt;
   ptr_t  wr_gray_nxt;
   logic  wr_full;
   logic  push;
   ptr_t  rd_bin;
   ptr_t  rd_gray;
   ptr_t  rd_bin_nxt;
   ptr_t  rd_gray_nxt;
   logic  rd_empty;
   logic  pop;

   assign gray_ptr[0] = wr_gray;
   assign gray_ptr[1] = rd_gray;

   assign push        = in_tvalid & ~wr_full;
   assign in_tready   = ~wr_full;
   assign wr_bin_nxt  = wr_bin + ptr_t'(push);
   assign wr_gray_nxt = bin2gray(wr_bin_nxt);

   always_ff @(posedge i_s_axis_aclk or negedge dom_rst_n[0]) begin
      if (!dom_rst_n[0]) begin
         wr_bin  <= '0;
         wr_gray <= '0;
         wr_full <= 1'b1;  // keeps tready low until the write domain leaves reset.
      end else begin
         wr_bin  <= wr_bin_nxt;
         wr_gray <= wr_gray_nxt;
         // full when the gray pointers differ only in their top two bits.
         wr_full <= wr_gray_nxt == {~gray_sync[0][DEPTH_LOG2 -: 2],
                                    gray_sync[0][DEPTH_LOG2-2:0]};
      end
   end

   always_ff @(posedge i_s_axis_aclk) begin
      if (push) begin
         mem[wr_bin[DEPTH_LOG2-1:0]] <= in_tdata;
      end
   end

   assign pop         = ~rd_empty & out_tready;
   assign out_tvalid  = ~rd_empty;
   assign out_tdata   = mem[rd_bin[DEPTH_LOG2-1:0]];  // asynchronous read port.
   assign rd_bin_nxt  = rd_bin + ptr_t'(pop);
   assign rd_gray_nxt = bin2gray(rd_bin_nxt);

   always_ff @(posedge i_m_axis_aclk or negedge dom_rst_n[1]) begin
      if (!dom_rst_n[1]) begin
         rd_bin   <= '0;
         rd_gray  <= '0;
         rd_empty <= 1'b1;
      end else begin
         rd_bin   <= rd_bin_nxt;
         rd_gray  <= rd_gray_nxt;
         rd_empty <= rd_gray_nxt == gray_sync[1];  // empty when the pointers match.
      end
   end

endmodule

// ==== design/axis_pkt_arbiter.sv ====
/* Round-robin packet arbiter for two streams in one clock domain. A grant lasts until
   the tlast transfer, so packets are never interleaved. Inputs must be quiet at reset release. */
module axis_pkt_arbiter #(
   parameter int WIDTH = 72
) (
   input  logic                i_m_axis_aclk,
   input  logic                i_arst_n,
   axis_if.sink                a,
   axis_if.sink                b,
   output logic [WIDTH-1:0]    o_m_axis_tdata,
   output logic                o_m_axis_tlast,
   output stream_pkg::src_id_t o_m_axis_tid,
   output logic                o_m_axis_tvalid,
   input  logic                i_m_axis_tready
);

   stream_pkg::arb_state_t state;
   stream_pkg::src_id_t    grant;     // source held for the packet in flight.
   stream_pkg::src_id_t    last_srv;  // source whose packet ended most recently.
   stream_pkg::src_id_t    pick;
   stream_pkg::src_id_t    sel;
   logic                   xfer_last;

   // Prefer the source after the last one served and fall back to the other.
   always_comb begin
      if (last_srv == stream_pkg::SRC_A) begin
         pick = b.tvalid ? stream_pkg::SRC_B : stream_pkg::SRC_A;
      end else begin
         pick = a.tvalid ? stream_pkg::SRC_A : stream_pkg::SRC_B;
      end
   end

   assign sel = (state == stream_pkg::ARB_BUSY) ? grant : pick;

   always_comb begin
      if (sel == stream_pkg::SRC_A) begin
         o_m_axis_tdata  = a.tdata;
         o_m_axis_tlast  = a.tlast;
         o_m_axis_tvalid = a.tvalid;
      end else begin
         o_m_axis_tdata  = b.tdata;
         o_m_axis_tlast  = b.tlast;
         o_m_axis_tvalid = b.tvalid;
      end
   end

   assign o_m_axis_tid = sel;
   assign a.tready     = i_m_axis_tready & (sel == stream_pkg::SRC_A);
   assign b.tready     = i_m_axis_tready & (sel == stream_pkg::SRC_B);
   assign xfer_last    = o_m_axis_tvalid & i_m_axis_tready & o_m_axis_tlast;

   always_ff @(posedge i_m_axis_aclk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state    <= stream_pkg::ARB_IDLE;
         grant    <= stream_pkg::SRC_A;
         last_srv <= stream_pkg::SRC_B;  // source a is served first.
      end else begin
         if (xfer_last) begin
            last_srv <= sel;
         end
         case (state)
            stream_pkg::ARB_IDLE: begin
               // a one-word packet finishes here without a grant.
               if (o_m_axis_tvalid && !xfer_last) begin
                  grant <= pick;
                  state <= stream_pkg::ARB_BUSY;
               end
            end
            stream_pkg::ARB_BUSY: begin
               if (xfer_last) begin
                  state <= stream_pkg::ARB_IDLE;
               end
            end
            default: state <= stream_pkg::ARB_IDLE;
         endcase
      end
   end

endmodule

// ==== design/axis_cdc_merge.sv ====
/* Merges two streams from the i_s_axis_aclk domain onto one stream in the i_m_axis_aclk domain.
   o_m_axis_tid names the source of each word. Whole packets are granted in round-robin order. */
module axis_cdc_merge #(
   parameter int    WIDTH      = stream_pkg::DATA_W,
   parameter int    DEPTH_LOG2 = stream_pkg::DEPTH_LOG2,
   parameter string PIPELINE   = "INOUT"
) (
   input  logic                i_arst_n,
   input  logic                i_s_axis_aclk,
   input  logic [WIDTH-1:0]    i_s_a_axis_tdata,
   input  logic                i_s_a_axis_tlast,
   input  logic                i_s_a_axis_tvalid,
   output logic                o_s_a_axis_tready,
   input  logic [WIDTH-1:0]    i_s_b_axis_tdata,
   input  logic                i_s_b_axis_tlast,
   input  logic                i_s_b_axis_tvalid,
   output logic                o_s_b_axis_tready,
   input  logic                i_m_axis_aclk,
   output logic [WIDTH-1:0]    o_m_axis_tdata,
   output logic                o_m_axis_tlast,
   output stream_pkg::src_id_t o_m_axis_tid,
   output logic                o_m_axis_tvalid,
   input  logic                i_m_axis_tready
);

   axis_if #(.WIDTH(WIDTH)) fifo_a_if ();  // fifo a output in the i_m_axis_aclk domain.
   axis_if #(.WIDTH(WIDTH)) fifo_b_if ();  // fifo b output in the i_m_axis_aclk domain.

   axis_2clk_fifo #(
      .WIDTH      (WIDTH),
      .DEPTH_LOG2 (DEPTH_LOG2),
      .PIPELINE   (PIPELINE)
   ) fifo_a_i (
      .i_arst_n        (i_arst_n),
      .i_s_axis_aclk   (i_s_axis_aclk),
      .i_s_axis_tdata  (i_s_a_axis_tdata),
      .i_s_axis_tlast  (i_s_a_axis_tlast),
      .i_s_axis_tvalid (i_s_a_axis_tvalid),
      .o_s_axis_tready (o_s_a_axis_tready),
      .i_m_axis_aclk   (i_m_axis_aclk),
      .m               (fifo_a_if.source)
   );

   axis_2clk_fifo #(
      .WIDTH      (WIDTH),
      .DEPTH_LOG2 (DEPTH_LOG2),
      .PIPELINE   (PIPELINE)
   ) fifo_b_i (
      .i_arst_n        (i_arst_n),
      .i_s_axis_aclk   (i_s_axis_aclk),
      .i_s_axis_tdata  (i_s_b_axis_tdata),
      .i_s_axis_tlast  (i_s_b_axis_tlast),
      .i_s_axis_tvalid (i_s_b_axis_tvalid),
      .o_s_axis_tready (o_s_b_axis_tready),
      .i_m_axis_aclk   (i_m_axis_aclk),
      .m               (fifo_b_if.source)
   );

   axis_pkt_arbiter #(.WIDTH(WIDTH)) arb_i (
      .i_m_axis_aclk   (i_m_axis_aclk),
      .i_arst_n        (i_arst_n),
      .a               (fifo_a_if.sink),
      .b               (fifo_b_if.sink),
      .o_m_axis_tdata  (o_m_axis_tdata),
      .o_m_axis_tlast  (o_m_axis_tlast),
      .o_m_axis_tid    (o_m_axis_tid),
      .o_m_axis_tvalid (o_m_axis_tvalid),
      .i_m_axis_tready (i_m_axis_tready)
   );

endmodule

// ==== testbench/axis_cdc_assert.sv ====
/* Handshake rules for the merger ports. Hold checks are off while reset is low. */
module axis_cdc_assert #(
   parameter int WIDTH = 72
) (
   input logic             i_arst_n,
   input logic             i_s_clk,
   input logic [WIDTH-1:0] i_a_tdata,
   input logic             i_a_tlast,
   input logic             i_a_tvalid,
   input logic             i_a_tready,
   input logic [WIDTH-1:0] i_b_tdata,
   input logic             i_b_tlast,
   input logic             i_b_tvalid,
   input logic             i_b_tready,
   input logic             i_m_clk,
   input logic [WIDTH-1:0] i_m_tdata,
   input logic             i_m_tlast,
   input logic             i_m_tvalid,
   input logic             i_m_tready
);

   a_hold_p: assert property (@(posedge i_s_clk) disable iff (!i_arst_n)
      i_a_tvalid && !i_a_tready |=> i_a_tvalid && $stable(i_a_tdata) && $stable(i_a_tlast))
      else $error("source a dropped or changed a word before the handshake");

   b_hold_p: assert property (@(posedge i_s_clk) disable iff (!i_arst_n)
      i_b_tvalid && !i_b_tready |=> i_b_tvalid && $stable(i_b_tdata) && $stable(i_b_tlast))
      else $error("source b dropped or changed a word before the handshake");

   m_hold_p: assert property (@(posedge i_m_clk) disable iff (!i_arst_n)
      i_m_tvalid && !i_m_tready |=> i_m_tvalid && $stable(i_m_tdata) && $stable(i_m_tlast))
      else $error("output dropped or changed a word before the handshake");

   m_reset_p: assert property (@(posedge i_m_clk) !i_arst_n |-> !i_m_tvalid)
      else $error("output tvalid is high during reset");

endmodule

bind axis_cdc_merge axis_cdc_assert #(.WIDTH(WIDTH)) assert_i (
   .i_arst_n   (i_arst_n),
   .i_s_clk    (i_s_axis_aclk),
   .i_a_tdata  (i_s_a_axis_tdata),
   .i_a_tlast  (i_s_a_axis_tlast),
   .i_a_tvalid (i_s_a_axis_tvalid),
   .i_a_tready (o_s_a_axis_tready),
   .i_b_tdata  (i_s_b_axis_tdata),
   .i_b_tlast  (i_s_b_axis_tlast),
   .i_b_tvalid (i_s_b_axis_tvalid),
   .i_b_tready (o_s_b_axis_tready),
   .i_m_clk    (i_m_axis_aclk),
   .i_m_tdata  (o_m_axis_tdata),
   .i_m_tlast  (o_m_axis_tlast),
   .i_m_tvalid (o_m_axis_tvalid),
   .i_m_tready (i_m_axis_tready)
);

// ==== testbench/tb_axis_cdc_merge.sv ====
/* Random packet testbench for the two-source merger with reference queues per source.
   Source clock period is 8 and destination clock period is 11, so edges drift freely. */
module tb_axis_cdc_merge;

   localparam int WORD_TIMEOUT  = 2000;  // source cycles allowed for one word.
   localparam int DRAIN_TIMEOUT = 4000;  // source cycles allowed to empty the queues.
   localparam int FILL_TIMEOUT  = 3000;

   logic                arst_n;
   logic                s_clk = 1'b0;
   logic                m_clk = 1'b0;
   logic [71:0]         s_tdata  [2];
   logic                s_tlast  [2];
   logic                s_tvalid [2];
   logic                s_tready [2];
   logic                s_acc    [2] = '{1'b0, 1'b0};  // word taken on the last source edge.
   logic                saw_full [2] = '{1'b0, 1'b0};
   logic [71:0]         m_tdata;
   logic                m_tlast;
   stream_pkg::src_id_t m_tid;
   logic                m_tvalid;
   logic                m_tready;
   int                  rdy_mode;     // 0 ready, 1 random, 2 long stretches, 3 held low.
   int                  stretch_cnt = 0;
   logic [72:0]         ref_a [$];    // expected {tlast, tdata} of source a.
   logic [72:0]         ref_b [$];
   logic                pkt_order [$];
   logic [72:0]         exp_word;
   logic                in_pkt = 1'b0;
   logic                pkt_tid = 1'b0;
   string               test_name;
   int                  err_count = 0;
   int                  test_errs = 0;
   int                  tests_run = 0;
   int                  tests_failed = 0;

   axis_cdc_merge #(.WIDTH(72), .DEPTH_LOG2(4), .PIPELINE("INOUT")) dut_i (
      .i_arst_n          (arst_n),
      .i_s_axis_aclk     (s_clk),
      .i_s_a_axis_tdata  (s_tdata[0]),
      .i_s_a_axis_tlast  (s_tlast[0]),
      .i_s_a_axis_tvalid (s_tvalid[0]),
      .o_s_a_axis_tready (s_tready[0]),
      .i_s_b_axis_tdata  (s_tdata[1]),
      .i_s_b_axis_tlast  (s_tlast[1]),
      .i_s_b_axis_tvalid (s_tvalid[1]),
      .o_s_b_axis_tready (s_tready[1]),
      .i_m_axis_aclk     (m_clk),
      .o_m_axis_tdata    (m_tdata),
      .o_m_axis_tlast    (m_tlast),
      .o_m_axis_tid      (m_tid),
      .o_m_axis_tvalid   (m_tvalid),
      .i_m_axis_tready   (m_tready)
   );

   initial begin
      forever #4 s_clk = ~s_clk;
   end

   initial begin
      forever begin
         #5 m_clk = 1'b1;  // 5 low plus 6 high gives a period of 11.
         #6 m_clk = 1'b0;
      end
   end

   task automatic check_value(input string what, input logic [72:0] expected,
                              input logic [72:0] actual);
      if (expected !== actual) begin
         $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, expected, actual);
         err_count++;
      end
   endtask

   // Accepted source words go into the reference queues in the order the FIFO took them.
   always @(posedge s_clk) begin
      for (int i = 0; i < 2; i++) begin
         s_acc[i] <= s_tvalid[i] & s_tready[i];
         if (s_tvalid[i] && !s_tready[i]) saw_full[i] = 1'b1;
      end
      if (s_tvalid[0] && s_tready[0]) ref_a.push_back({s_tlast[0], s_tdata[0]});
      if (s_tvalid[1] && s_tready[1]) ref_b.push_back({s_tlast[1], s_tdata[1]});
   end

   always @(posedge m_clk) begin
      if (m_tvalid && m_tready) begin
         if (in_pkt) check_value("tid inside a packet", {72'd0, pkt_tid}, {72'd0, m_tid});
         if (m_tid == 1'b0 && ref_a.size() > 0) begin
            exp_word = ref_a.pop_front();
            check_value("source a word", exp_word, {m_tlast, m_tdata});
         end else if (m_tid == 1'b1 && ref_b.size() > 0) begin
            exp_word = ref_b.pop_front();
            check_value("source b word", exp_word, {m_tlast, m_tdata});
         end else begin
            $display("ERROR %s: a word from source %0d arrived but none was sent", test_name, m_tid);
            err_count++;
         end
         in_pkt  = ~m_tlast;
         pkt_tid = m_tid;
         if (m_tlast) pkt_order.push_back(m_tid);
      end
   end

   // Output ready pattern, changed on the falling destination edge.
   task automatic drive_ready();
      forever begin
         @(negedge m_clk);
         case (rdy_mode)
            0: m_tready = 1'b1;
            1: m_tready = ($urandom_range(3) != 0);
            2: begin
               if (stretch_cnt == 0) begin
                  m_tready    = ~m_tready;
                  stretch_cnt = m_tready ? $urandom_range(20, 5) : $urandom_range(150, 60);
               end else begin
                  stretch_cnt--;
               end
            end
            default: m_tready = 1'b0;
         endcase
      end
   endtask

   // The new mode is taken up on the next falling destination edge.
   // The caller resumes on a falling source edge.
   task automatic set_ready_mode(input int mode);
      @(posedge m_clk);
      rdy_mode = mode;
      @(negedge s_clk);
   endtask

   task automatic send_packets(input int src, input int npkt, input int max_gap);
      int          n_words;
      int          gap;
      int          t;
      logic [71:0] payload;
      for (int p = 0; p < npkt; p++) begin
         n_words = 1 + $urandom_range(7);
         for (int w = 0; w < n_words; w++) begin
            payload[31:0]  = $urandom();
            payload[63:32] = $urandom();
            payload[71:64] = 8'($urandom());
            s_tdata[src]   = payload;
            s_tlast[src]   = (w == n_words - 1);
            s_tvalid[src]  = 1'b1;
            t = 0;
            do begin
               @(negedge s_clk);
               t++;
            end while (!s_acc[src] && t < WORD_TIMEOUT);
            if (!s_acc[src]) begin
               $display("ERROR %s: source %0d word was never accepted", test_name, src);
               err_count++;
               s_tvalid[src] = 1'b0;
               return;
            end
            gap = (max_gap > 0) ? $urandom_range(max_gap) : 0;
            if (gap > 0) begin
               s_tvalid[src] = 1'b0;
               repeat (gap) @(negedge s_clk);
            end
         end
      end
      s_tvalid[src] = 1'b0;
   endtask

   task automatic wait_drain();
      int t;
      t = 0;
      while ((ref_a.size() != 0 || ref_b.size() != 0) && t < DRAIN_TIMEOUT) begin
         @(negedge s_clk);
         t++;
      end
      if (ref_a.size() != 0 || ref_b.size() != 0) begin
         $display("ERROR %s: words still missing at the output after the drain time", test_name);
         err_count++;
      end
   endtask

   // Holds the output low until both sources see a full FIFO, then lets it run.
   task automatic release_when_full();
      int t;
      t = 0;
      while (!(saw_full[0] && saw_full[1]) && t < FILL_TIMEOUT) begin
         @(negedge s_clk);
         t++;
      end
      if (!(saw_full[0] && saw_full[1])) begin
         $display("ERROR %s: the source FIFOs never filled up", test_name);
         err_count++;
      end
      set_ready_mode(0);
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errs = err_count;
      pkt_order.delete();
      saw_full[0] = 1'b0;
      saw_full[1] = 1'b0;
   endtask

   task automatic end_test();
      tests_run++;
      if (err_count == test_errs) begin
         $display("test %s: ok", test_name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", test_name, err_count - test_errs);
      end
   endtask

   initial begin
      int t;
      void'($urandom(32'h0a8334a2));
      arst_n   = 1'b0;
      rdy_mode = 3;
      m_tready = 1'b0;
      for (int i = 0; i < 2; i++) begin
         s_tdata[i]  = '0;
         s_tlast[i]  = 1'b0;
         s_tvalid[i] = 1'b0;
      end
      fork
         drive_ready();
      join_none

      start_test("reset_state");
      repeat (4) begin
         @(negedge s_clk);
         check_value("o_m_axis_tvalid", 73'd0, {72'd0, m_tvalid});
         check_value("o_s_a_axis_tready", 73'd0, {72'd0, s_tready[0]});
         check_value("o_s_b_axis_tready", 73'd0, {72'd0, s_tready[1]});
      end
      arst_n = 1'b1;
      t = 0;
      while (!(s_tready[0] && s_tready[1]) && t < 50) begin
         @(negedge s_clk);
         t++;
      end
      if (!(s_tready[0] && s_tready[1])) begin
         $display("ERROR %s: source tready did not rise after reset release", test_name);
         err_count++;
      end
      end_test();

      start_test("single_source_a");
      set_ready_mode(1);
      send_packets(0, 12, 3);
      wait_drain();
      end_test();

      start_test("single_source_b");
      send_packets(1, 12, 3);
      wait_drain();
      end_test();

      start_test("merge");
      fork
         send_packets(0, 20, 3);
         send_packets(1, 20, 3);
      join
      set_ready_mode(0);
      wait_drain();
      end_test();

      start_test("fairness");
      set_ready_mode(3);
      fork
         send_packets(0, 20, 0);
         send_packets(1, 20, 0);
         release_when_full();
      join
      wait_drain();
      // the tail is skipped because one source may run dry a packet early.
      for (int i = 1; i < pkt_order.size() - 4; i++) begin
         check_value("packet source order", {72'd0, ~pkt_order[i-1]}, {72'd0, pkt_order[i]});
      end
      end_test();

      start_test("backpressure");
      set_ready_mode(2);
      fork
         send_packets(0, 20, 1);
         send_packets(1, 20, 1);
      join
      set_ready_mode(0);
      wait_drain();
      check_value("source a tready fell when full", 73'd1, {72'd0, saw_full[0]});
      check_value("source b tready fell when full", 73'd1, {72'd0, saw_full[1]});
      end_test();

      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_count);
      if (err_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
design/stream_pkg.sv
design/axis_if.sv
design/axis_flop2.sv
design/axis_2clk_fifo.sv
design/axis_pkt_arbiter.sv
design/axis_cdc_merge.sv
testbench/axis_cdc_assert.sv
testbench/tb_axis_cdc_merge.sv

// ==== Bender.yml ====
package:
  name: axis_cdc_merge

sources:
  - files:
      - design/stream_pkg.sv
      - design/axis_if.sv
      - design/axis_flop2.sv
      - design/axis_2clk_fifo.sv
      - design/axis_pkt_arbiter.sv
      - design/axis_cdc_merge.sv
  - target: test
    files:
      - testbench/axis_cdc_assert.sv
      - testbench/tb_axis_cdc_merge.sv
